// ==== logic/id_pkg.sv ====
// Widths and encodings shared by the RV32I decode stage
// Imported by every RTL module of the stage and by its testbench

package id_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Data path and instruction word
  localparam int unsigned XLEN       = 32;
  // Register file index
  localparam int unsigned REG_ADDR_W = 5;

  //////////////////////////////
  // Instruction encodings
  //////////////////////////////

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  //////////////////////////////
  // Datapath controls
  //////////////////////////////

  // Arithmetic, shifts, set-less-than, then branch comparisons
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB,
    ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;

  // Operand B source
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  // Immediate format feeding operand B
  // INCR_PC is the return address offset of a jump
  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  // Data access size
  typedef enum logic [1:0] {LSU_WORD = 2'b00, LSU_HALF = 2'b01, LSU_BYTE = 2'b10} lsu_type_e;

  // Decode stage state
  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

endpackage

// ==== logic/id_decoder.sv ====
// Combinational RV32I decoder of the decode stage
// Turns the instruction word into ALU selects, register addresses and the
// class flags that the stage FSM uses to plan its stalls

`timescale 1ns/1ps

module id_decoder (
  input  logic [id_pkg::XLEN-1:0]       instr_rdata_i,
  output id_pkg::alu_op_e               alu_operator_o,
  output id_pkg::op_a_sel_e             alu_op_a_mux_sel_o,
  output id_pkg::op_b_sel_e             alu_op_b_mux_sel_o,
  output id_pkg::imm_b_sel_e            imm_b_mux_sel_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic                          rf_we_o,
  output logic                          lsu_req_o,
  output logic                          lsu_we_o,
  output id_pkg::lsu_type_e             lsu_type_o,
  output logic                          lsu_sign_ext_o,
  output logic                          branch_in_dec_o,
  output logic                          jump_in_dec_o,
  output logic                          illegal_insn_o
);

  import id_pkg::*;

  logic [6:0] funct7;
  logic [2:0] funct3;

  assign funct7 = instr_rdata_i[31:25];
  assign funct3 = instr_rdata_i[14:12];

  // Register fields sit at fixed positions in every format
  assign rf_raddr_a_o = instr_rdata_i[19:15];
  assign rf_raddr_b_o = instr_rdata_i[24:20];
  assign rf_waddr_o   = instr_rdata_i[11:7];

  // Access size from the low funct3 bits, same for loads and stores
  always_comb begin
    unique case (funct3[1:0])
      2'b00:   lsu_type_o = LSU_BYTE;
      2'b01:   lsu_type_o = LSU_HALF;
      default: lsu_type_o = LSU_WORD;
    endcase
  end

  always_comb begin
    // Defaults describe a register-immediate add with no side effects
    alu_operator_o     = ALU_ADD;
    alu_op_a_mux_sel_o = OP_A_REG_A;
    alu_op_b_mux_sel_o = OP_B_IMM;
    imm_b_mux_sel_o    = IMM_B_I;
    rf_we_o            = 1'b0;
    lsu_req_o          = 1'b0;
    lsu_we_o           = 1'b0;
    lsu_sign_ext_o     = 1'b0;
    branch_in_dec_o    = 1'b0;
    jump_in_dec_o      = 1'b0;
    illegal_insn_o     = 1'b0;

    unique case (opcode_e'(instr_rdata_i[6:0]))
      // Link address PC+4 goes through the ALU
      OPC_JAL, OPC_JALR: begin
        jump_in_dec_o      = 1'b1;
        rf_we_o            = 1'b1;
        alu_op_a_mux_sel_o = OP_A_CURRPC;
        imm_b_mux_sel_o    = IMM_B_INCR_PC;
        illegal_insn_o     = (instr_rdata_i[6:0] == OPC_JALR) && (funct3 != 3'b000);
      end
      // Condition compares rs1 against rs2
      OPC_BRANCH: begin
        branch_in_dec_o    = 1'b1;
        alu_op_b_mux_sel_o = OP_B_REG_B;
        imm_b_mux_sel_o    = IMM_B_B;
        unique case (funct3)
          3'b000:  alu_operator_o = ALU_EQ;
          3'b001:  alu_operator_o = ALU_NE;
          3'b100:  alu_operator_o = ALU_LT;
          3'b101:  alu_operator_o = ALU_GE;
          3'b110:  alu_operator_o = ALU_LTU;
          3'b111:  alu_operator_o = ALU_GEU;
          default: illegal_insn_o = 1'b1;
        endcase
      end
      // Address is rs1 plus the offset
      OPC_LOAD: begin
        lsu_req_o      = 1'b1;
        rf_we_o        = 1'b1;
        lsu_sign_ext_o = ~funct3[2];
        illegal_insn_o = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPC_STORE: begin
        lsu_req_o       = 1'b1;
        lsu_we_o        = 1'b1;
        imm_b_mux_sel_o = IMM_B_S;
        illegal_insn_o  = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPC_LUI: begin
        rf_we_o            = 1'b1;
        alu_op_a_mux_sel_o = OP_A_ZERO;
        imm_b_mux_sel_o    = IMM_B_U;
      end
      OPC_AUIPC: begin
        rf_we_o            = 1'b1;
        alu_op_a_mux_sel_o = OP_A_CURRPC;
        imm_b_mux_sel_o    = IMM_B_U;
      end
      OPC_OP_IMM: begin
        rf_we_o = 1'b1;
        unique case (funct3)
          3'b000: alu_operator_o = ALU_ADD;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
          3'b001: begin
            alu_operator_o = ALU_SLL;
            illegal_insn_o = (funct7 != 7'b0);
          end
          3'b101: begin
            // Bit 30 picks the arithmetic shift
            alu_operator_o = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal_insn_o = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end
      OPC_OP: begin
        rf_we_o            = 1'b1;
        alu_op_b_mux_sel_o = OP_B_REG_B;
        unique case (funct3)
          3'b000: alu_operator_o = funct7[5] ? ALU_SUB : ALU_ADD;
          3'b001: alu_operator_o = ALU_SLL;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b101: alu_operator_o = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
        endcase
        // Only 0000000 and 0100000 exist, the latter just for SUB and SRA
        if ({funct7[6], funct7[4:0]} != 6'b0) begin
          illegal_insn_o = 1'b1;
        end else if (funct7[5] && (funct3 != 3'b000) && (funct3 != 3'b101)) begin
          illegal_insn_o = 1'b1;
        end
      end
      default: illegal_insn_o = 1'b1;
    endcase

    // An illegal word must not write, access memory or redirect fetch
    if (illegal_insn_o) begin
      rf_we_o         = 1'b0;
      lsu_req_o       = 1'b0;
      lsu_we_o        = 1'b0;
      branch_in_dec_o = 1'b0;
      jump_in_dec_o   = 1'b0;
    end
  end

  // The FSM serves one multicycle class at a time
  always_comb begin
    assert final ($onehot0({lsu_req_o, branch_in_dec_o, jump_in_dec_o}))
      else $error("decoder raised more than one multicycle class");
  end

endmodule

// ==== logic/id_operand_mux.sv ====
// Immediate generation and ALU operand selection of the decode stage
// Selects come from the decoder, data from the PC and the register file

`timescale 1ns/1ps

module id_operand_mux (
  input  logic [id_pkg::XLEN-1:0] instr_rdata_i,
  input  logic [id_pkg::XLEN-1:0] pc_id_i,
  input  logic [id_pkg::XLEN-1:0] rf_rdata_a_i,
  input  logic [id_pkg::XLEN-1:0] rf_rdata_b_i,
  input  id_pkg::op_a_sel_e       alu_op_a_mux_sel_i,
  input  id_pkg::op_b_sel_e       alu_op_b_mux_sel_i,
  input  id_pkg::imm_b_sel_e      imm_b_mux_sel_i,
  output logic [id_pkg::XLEN-1:0] alu_operand_a_o,
  output logic [id_pkg::XLEN-1:0] alu_operand_b_o
);

  import id_pkg::*;

  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_b_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_j_type;
  logic [XLEN-1:0] imm_b;

  // Sign bit is always instruction bit 31
  assign imm_i_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_b_type = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                       instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_u_type = {instr_rdata_i[31:12], 12'b0};
  assign imm_j_type = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                       instr_rdata_i[30:21], 1'b0};

  always_comb begin
    unique case (imm_b_mux_sel_i)
      IMM_B_I:       imm_b = imm_i_type;
      IMM_B_S:       imm_b = imm_s_type;
      IMM_B_B:       imm_b = imm_b_type;
      IMM_B_U:       imm_b = imm_u_type;
      IMM_B_J:       imm_b = imm_j_type;
      // No compressed instructions, so the link offset is always 4
      IMM_B_INCR_PC: imm_b = 32'h4;
      default:       imm_b = 32'h4;
    endcase
  end

  always_comb begin
    unique case (alu_op_a_mux_sel_i)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      default:     alu_operand_a_o = '0;
    endcase
  end

  assign alu_operand_b_o = (alu_op_b_mux_sel_i == OP_B_IMM) ? imm_b : rf_rdata_b_i;

  // Decoder must hand over a defined immediate format
  always_comb begin
    assert final (imm_b_mux_sel_i inside {IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J,
                                          IMM_B_INCR_PC})
      else $error("undefined immediate select %0d", imm_b_mux_sel_i);
  end

endmodule

// ==== logic/id_fsm.sv ====
// First-cycle/multi-cycle control of the decode stage
// Derives stalls, the done cycle and the PC set, and gates the decoder enables

`timescale 1ns/1ps

module id_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_valid_i,
  input  logic branch_decision_i,
  input  logic lsu_resp_valid_i,
  input  logic lsu_req_dec_i,
  input  logic branch_in_dec_i,
  input  logic jump_in_dec_i,
  input  logic rf_we_dec_i,
  input  logic illegal_insn_dec_i,
  output logic lsu_req_o,
  output logic rf_we_o,
  output logic pc_set_o,
  output logic illegal_insn_o,
  output logic id_in_ready_o,
  output logic instr_done_o
);

  import id_pkg::*;

  id_fsm_e id_fsm_q;
  id_fsm_e id_fsm_d;
  logic    instr_first_cycle;
  logic    multicycle_done;
  logic    stall_mem;
  logic    stall_branch;
  logic    stall_jump;
  logic    stall_id;
  logic    branch_set_d;
  logic    branch_set_q;
  logic    jump_set;

  //////////////////////////////
  // State and branch set
  //////////////////////////////

  // State only advances while an instruction is present
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q     <= FIRST_CYCLE;
      branch_set_q <= 1'b0;
    end else begin
      branch_set_q <= branch_set_d;
      if (instr_valid_i) begin
        id_fsm_q <= id_fsm_d;
      end
    end
  end

  assign instr_first_cycle = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  // Branches and jumps leave after one extra cycle, memory waits for the response
  assign multicycle_done = ~lsu_req_dec_i | lsu_resp_valid_i;

  always_comb begin
    id_fsm_d     = id_fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set     = 1'b0;
    if (instr_valid_i) begin
      unique case (id_fsm_q)
        FIRST_CYCLE: begin
          if (lsu_req_dec_i) begin
            id_fsm_d = MULTI_CYCLE;
          end else if (branch_in_dec_i) begin
            // Taken decision is flopped and sets the PC next cycle
            id_fsm_d     = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (jump_in_dec_i) begin
            // Jump redirects fetch now and writes the link next cycle
            id_fsm_d   = MULTI_CYCLE;
            stall_jump = 1'b1;
            jump_set   = 1'b1;
          end
        end
        MULTI_CYCLE: begin
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end
        end
      endcase
    end
  end

  //////////////////////////////
  // Stalls and gated outputs
  //////////////////////////////

  // Memory access always holds the first cycle, then waits for the response pulse
  assign stall_mem = instr_valid_i & lsu_req_dec_i & (~lsu_resp_valid_i | instr_first_cycle);
  assign stall_id  = stall_mem | stall_branch | stall_jump;

  assign instr_done_o   = instr_valid_i & ~stall_id;
  assign id_in_ready_o  = instr_done_o | ~instr_valid_i;
  // Request is issued once, in the first cycle
  assign lsu_req_o      = instr_first_cycle & lsu_req_dec_i;
  // Write happens in the done cycle only
  assign rf_we_o        = rf_we_dec_i & instr_done_o;
  assign pc_set_o       = instr_valid_i & (jump_set | branch_set_q);
  assign illegal_insn_o = instr_valid_i & illegal_insn_dec_i;

  // Entering MULTI_CYCLE always holds the instruction in the stage
  a_multicycle_stalls: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (id_fsm_q == FIRST_CYCLE) && (id_fsm_d == MULTI_CYCLE) |-> stall_id)
    else $error("move to MULTI_CYCLE without a stall");

  // Only memory, branch and jump instructions may hold the stage
  a_valid_done_or_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i && !instr_done_o |-> (lsu_req_dec_i || branch_in_dec_i || jump_in_dec_i))
    else $error("valid instruction held without a multicycle class");

endmodule

// ==== logic/id_stage.sv ====
// Top level of the RV32I decode stage without a writeback stage
// Connects the decoder, the operand mux and the stage FSM

`timescale 1ns/1ps

module id_stage (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Fetch/decode pipeline register
  input  logic                          instr_valid_i,
  input  logic [id_pkg::XLEN-1:0]       instr_rdata_i,
  input  logic [id_pkg::XLEN-1:0]       pc_id_i,
  // Register file read data
  input  logic [id_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [id_pkg::XLEN-1:0]       rf_rdata_b_i,
  // Feedback from execute and memory
  input  logic                          branch_decision_i,
  input  logic                          lsu_resp_valid_i,
  // ALU
  output id_pkg::alu_op_e               alu_operator_o,
  output logic [id_pkg::XLEN-1:0]       alu_operand_a_o,
  output logic [id_pkg::XLEN-1:0]       alu_operand_b_o,
  // Register file
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic                          rf_we_o,
  // Load/store unit
  output logic                          lsu_req_o,
  output logic                          lsu_we_o,
  output id_pkg::lsu_type_e             lsu_type_o,
  output logic                          lsu_sign_ext_o,
  output logic [id_pkg::XLEN-1:0]       lsu_wdata_o,
  // Stage control
  output logic                          pc_set_o,
  output logic                          illegal_insn_o,
  output logic                          id_in_ready_o,
  output logic                          instr_done_o
);

  import id_pkg::*;

  // Operand selects from the decoder
  op_a_sel_e  alu_op_a_mux_sel;
  op_b_sel_e  alu_op_b_mux_sel;
  imm_b_sel_e imm_b_mux_sel;

  // Ungated class flags for the FSM
  logic lsu_req_dec;
  logic branch_in_dec;
  logic jump_in_dec;
  logic rf_we_dec;
  logic illegal_insn_dec;

  id_decoder decoder_i (
    .instr_rdata_i     (instr_rdata_i),
    .alu_operator_o    (alu_operator_o),
    .alu_op_a_mux_sel_o(alu_op_a_mux_sel),
    .alu_op_b_mux_sel_o(alu_op_b_mux_sel),
    .imm_b_mux_sel_o   (imm_b_mux_sel),
    .rf_raddr_a_o      (rf_raddr_a_o),
    .rf_raddr_b_o      (rf_raddr_b_o),
    .rf_waddr_o        (rf_waddr_o),
    .rf_we_o           (rf_we_dec),
    .lsu_req_o         (lsu_req_dec),
    .lsu_we_o          (lsu_we_o),
    .lsu_type_o        (lsu_type_o),
    .lsu_sign_ext_o    (lsu_sign_ext_o),
    .branch_in_dec_o   (branch_in_dec),
    .jump_in_dec_o     (jump_in_dec),
    .illegal_insn_o    (illegal_insn_dec)
  );

  id_operand_mux operand_mux_i (
    .instr_rdata_i     (instr_rdata_i),
    .pc_id_i           (pc_id_i),
    .rf_rdata_a_i      (rf_rdata_a_i),
    .rf_rdata_b_i      (rf_rdata_b_i),
    .alu_op_a_mux_sel_i(alu_op_a_mux_sel),
    .alu_op_b_mux_sel_i(alu_op_b_mux_sel),
    .imm_b_mux_sel_i   (imm_b_mux_sel),
    .alu_operand_a_o   (alu_operand_a_o),
    .alu_operand_b_o   (alu_operand_b_o)
  );

  id_fsm fsm_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .branch_decision_i (branch_decision_i),
    .lsu_resp_valid_i  (lsu_resp_valid_i),
    .lsu_req_dec_i     (lsu_req_dec),
    .branch_in_dec_i   (branch_in_dec),
    .jump_in_dec_i     (jump_in_dec),
    .rf_we_dec_i       (rf_we_dec),
    .illegal_insn_dec_i(illegal_insn_dec),
    .lsu_req_o         (lsu_req_o),
    .rf_we_o           (rf_we_o),
    .pc_set_o          (pc_set_o),
    .illegal_insn_o    (illegal_insn_o),
    .id_in_ready_o     (id_in_ready_o),
    .instr_done_o      (instr_done_o)
  );

  // No forwarding path, store data comes straight from the register file
  assign lsu_wdata_o = rf_rdata_b_i;

endmodule

// ==== verification/id_stage_tb_cases.svh ====
// Instruction table for the decode stage testbench
// Included inside the testbench module after the row type is declared
// Register read data and LSU latency are drawn from the LFSR at run time

`ifndef ID_STAGE_TB_CASES_SVH
`define ID_STAGE_TB_CASES_SVH

localparam int N_CASES = 21;

// Columns: instr, pc, branch taken, operator, operand A source, B is immediate, immediate,
// write address, write enable, lsu_req, lsu_we, lsu_type, sign extension,
// pc_set cycle (0 = none), done cycle (0 = on the LSU response), illegal
case_t case_table [N_CASES] = '{
  '{32'h007302b3, 32'h00001000, 1'b1, ALU_ADD, OP_A_REG_A, 1'b0, 32'h00000000,
    5'd5, 1'b1, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b0},   // add x5, x6, x7
  '{32'h40c58533, 32'h00001004, 1'b0, ALU_SUB, OP_A_REG_A, 1'b0, 32'h00000000,
    5'd10, 1'b1, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b0},  // sub x10, x11, x12
  '{32'h407352b3, 32'h00001008, 1'b0, ALU_SRA, OP_A_REG_A, 1'b0, 32'h00000000,
    5'd5, 1'b1, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b0},   // sra x5, x6, x7
  '{32'hfff30293, 32'h0000100c, 1'b0, ALU_ADD, OP_A_REG_A, 1'b1, 32'hffffffff,
    5'd5, 1'b1, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b0},   // addi x5, x6, -1
  '{32'h7ff4a413, 32'h00001010, 1'b0, ALU_SLT, OP_A_REG_A, 1'b1, 32'h000007ff,
    5'd8, 1'b1, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b0},   // slti x8, x9, 2047
  '{32'hf0037293, 32'h00001014, 1'b0, ALU_AND, OP_A_REG_A, 1'b1, 32'hffffff00,
    5'd5, 1'b1, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b0},   // andi x5, x6, -256
  '{32'h40335293, 32'h00001018, 1'b0, ALU_SRA, OP_A_REG_A, 1'b1, 32'h00000403,
    5'd5, 1'b1, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b0},   // srai x5, x6, 3
  '{32'h123452b7, 32'h0000101c, 1'b0, ALU_ADD, OP_A_ZERO, 1'b1, 32'h12345000,
    5'd5, 1'b1, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b0},   // lui x5, 0x12345
  '{32'hfffff397, 32'h80000020, 1'b0, ALU_ADD, OP_A_CURRPC, 1'b1, 32'hfffff000,
    5'd7, 1'b1, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b0},   // auipc x7, 0xfffff
  '{32'h00832283, 32'h00002000, 1'b0, ALU_ADD, OP_A_REG_A, 1'b1, 32'h00000008,
    5'd5, 1'b1, 1'b1, 1'b0, LSU_WORD, 1'b1, 2'd0, 3'd0, 1'b0},   // lw x5, 8(x6)
  '{32'hffc10483, 32'h00002004, 1'b0, ALU_ADD, OP_A_REG_A, 1'b1, 32'hfffffffc,
    5'd9, 1'b1, 1'b1, 1'b0, LSU_BYTE, 1'b1, 2'd0, 3'd0, 1'b0},   // lb x9, -4(x2)
  '{32'h00235283, 32'h00002008, 1'b0, ALU_ADD, OP_A_REG_A, 1'b1, 32'h00000002,
    5'd5, 1'b1, 1'b1, 1'b0, LSU_HALF, 1'b0, 2'd0, 3'd0, 1'b0},   // lhu x5, 2(x6)
  '{32'h00732623, 32'h0000200c, 1'b0, ALU_ADD, OP_A_REG_A, 1'b1, 32'h0000000c,
    5'd12, 1'b0, 1'b1, 1'b1, LSU_WORD, 1'b0, 2'd0, 3'd0, 1'b0},  // sw x7, 12(x6)
  '{32'hfe730fa3, 32'h00002010, 1'b0, ALU_ADD, OP_A_REG_A, 1'b1, 32'hffffffff,
    5'd31, 1'b0, 1'b1, 1'b1, LSU_BYTE, 1'b0, 2'd0, 3'd0, 1'b0},  // sb x7, -1(x6)
  '{32'h00730863, 32'h00003000, 1'b1, ALU_EQ, OP_A_REG_A, 1'b0, 32'h00000000,
    5'd16, 1'b0, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd2, 3'd2, 1'b0},  // beq x6, x7, +16 taken
  '{32'hfe731ce3, 32'h00003004, 1'b0, ALU_NE, OP_A_REG_A, 1'b0, 32'h00000000,
    5'd25, 1'b0, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b0},  // bne x6, x7, -8 not taken
  '{32'h00945463, 32'h00003008, 1'b1, ALU_GE, OP_A_REG_A, 1'b0, 32'h00000000,
    5'd8, 1'b0, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd2, 3'd2, 1'b0},   // bge x8, x9, +8 taken
  '{32'h010000ef, 32'h00004000, 1'b1, ALU_ADD, OP_A_CURRPC, 1'b1, 32'h00000004,
    5'd1, 1'b1, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd1, 3'd2, 1'b0},   // jal x1, +16
  '{32'h000302e7, 32'h00004100, 1'b0, ALU_ADD, OP_A_CURRPC, 1'b1, 32'h00000004,
    5'd5, 1'b1, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd1, 3'd2, 1'b0},   // jalr x5, 0(x6)
  '{32'h0000000b, 32'h00005000, 1'b1, ALU_ADD, OP_A_REG_A, 1'b1, 32'h00000000,
    5'd0, 1'b0, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b1},   // custom-0 opcode
  '{32'h027302b3, 32'h00005004, 1'b0, ALU_ADD, OP_A_REG_A, 1'b0, 32'h00000000,
    5'd5, 1'b0, 1'b0, 1'b0, LSU_WORD, 1'b0, 2'd0, 3'd1, 1'b1}    // mul, funct7 not supported
};

`endif

// ==== verification/id_stage_tb.sv ====
// Testbench for the RV32I decode stage
// Applies each table row as one instruction and checks every cycle until done
// Register data and LSU latency come from a Fibonacci LFSR with a fixed seed

`timescale 1ns/1ps

module id_stage_tb;

  import id_pkg::*;

  // One instruction with its expected decode and timing
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        taken;
    alu_op_e     op;
    op_a_sel_e   a_sel;
    logic        b_imm;
    logic [31:0] imm;
    logic [4:0]  waddr;
    logic        we;
    logic        lsu_req;
    logic        lsu_we;
    lsu_type_e   lsu_type;
    logic        sign_ext;
    logic [1:0]  pc_set_cyc;
    logic [2:0]  done_cyc;
    logic        illegal;
  } case_t;

  `include "id_stage_tb_cases.svh"

  // Longest row is a load with 4 cycles of latency plus the idle cycle
  localparam int MAX_CYC     = 6;
  localparam int RESET_CYC   = 10;
  localparam int CYCLE_LIMIT = N_CASES * (4 + 2) + RESET_CYC + 20;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic            instr_valid_i;
  logic [31:0]     instr_rdata_i;
  logic [31:0]     pc_id_i;
  logic [31:0]     rf_rdata_a_i;
  logic [31:0]     rf_rdata_b_i;
  logic            branch_decision_i;
  logic            lsu_resp_valid_i;
  alu_op_e         alu_operator_o;
  logic [31:0]     alu_operand_a_o;
  logic [31:0]     alu_operand_b_o;
  logic [4:0]      rf_raddr_a_o;
  logic [4:0]      rf_raddr_b_o;
  logic [4:0]      rf_waddr_o;
  logic            rf_we_o;
  logic            lsu_req_o;
  logic            lsu_we_o;
  lsu_type_e       lsu_type_o;
  logic            lsu_sign_ext_o;
  logic [31:0]     lsu_wdata_o;
  logic            pc_set_o;
  logic            illegal_insn_o;
  logic            id_in_ready_o;
  logic            instr_done_o;

  // Bookkeeping
  logic [31:0] lfsr_q = 32'hc4e3;
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          cycle_cnt = 0;

  id_stage DUT (.*);

  // 40 ns period
  always #20 clk_i = ~clk_i;

  // Run limit derived from the table length
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else begin
        $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        err_cnt++;
      end
  endtask

  // No instruction present, so every pulse is low and the stage is ready
  task automatic check_idle();
    check_val("instr_done_o", 32'd0, 32'(instr_done_o));
    check_val("id_in_ready_o", 32'd1, 32'(id_in_ready_o));
    check_val("pc_set_o", 32'd0, 32'(pc_set_o));
    check_val("lsu_req_o", 32'd0, 32'(lsu_req_o));
    check_val("rf_we_o", 32'd0, 32'(rf_we_o));
    check_val("illegal_insn_o", 32'd0, 32'(illegal_insn_o));
  endtask

  //////////////////////////////
  // One table row
  //////////////////////////////

  task automatic run_case(input int idx);
    case_t       c;
    logic [31:0] rdata_a;
    logic [31:0] rdata_b;
    logic [31:0] delay;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    int          done_cyc;
    int          cyc;
    int          errs_before;
    bit          finished;

    c = case_table[idx];
    errs_before = err_cnt;
    draw_bits(32, rdata_a);
    draw_bits(32, rdata_b);
    draw_bits(2, delay);
    // Response arrives 1 to 4 cycles after the request cycle
    done_cyc = c.lsu_req ? 2 + int'(delay[1:0]) : int'(c.done_cyc);

    case (c.a_sel)
      OP_A_CURRPC: exp_a = c.pc;
      OP_A_ZERO:   exp_a = '0;
      default:     exp_a = rdata_a;
    endcase
    exp_b = c.b_imm ? c.imm : rdata_b;

    @(posedge clk_i);
    instr_valid_i     <= 1'b1;
    instr_rdata_i     <= c.instr;
    pc_id_i           <= c.pc;
    rf_rdata_a_i      <= rdata_a;
    rf_rdata_b_i      <= rdata_b;
    branch_decision_i <= c.taken;
    lsu_resp_valid_i  <= 1'b0;

    cyc = 1;
    finished = 1'b0;
    while (!finished) begin
      @(negedge clk_i);
      // Decode outputs hold in every cycle of the instruction
      check_val("alu_operator_o", 32'(c.op), 32'(alu_operator_o));
      check_val("alu_operand_a_o", exp_a, alu_operand_a_o);
      check_val("alu_operand_b_o", exp_b, alu_operand_b_o);
      check_val("rf_raddr_a_o", 32'(c.instr[19:15]), 32'(rf_raddr_a_o));
      check_val("rf_raddr_b_o", 32'(c.instr[24:20]), 32'(rf_raddr_b_o));
      check_val("rf_waddr_o", 32'(c.waddr), 32'(rf_waddr_o));
      check_val("lsu_we_o", 32'(c.lsu_we), 32'(lsu_we_o));
      check_val("lsu_wdata_o", rdata_b, lsu_wdata_o);
      check_val("illegal_insn_o", 32'(c.illegal), 32'(illegal_insn_o));
      if (c.lsu_req) begin
        check_val("lsu_type_o", 32'(c.lsu_type), 32'(lsu_type_o));
        check_val("lsu_sign_ext_o", 32'(c.sign_ext), 32'(lsu_sign_ext_o));
      end
      // Timing of the pulses
      check_val("lsu_req_o", 32'(c.lsu_req && (cyc == 1)), 32'(lsu_req_o));
      check_val("pc_set_o", 32'(cyc == int'(c.pc_set_cyc)), 32'(pc_set_o));
      check_val("rf_we_o", 32'(c.we && (cyc == done_cyc)), 32'(rf_we_o));
      check_val("instr_done_o", 32'(cyc == done_cyc), 32'(instr_done_o));
      check_val("id_in_ready_o", 32'(cyc == done_cyc), 32'(id_in_ready_o));

      if (instr_done_o) begin
        finished = 1'b1;
      end else if (cyc >= MAX_CYC) begin
        $display("case %0d: instruction did not finish within %0d cycles", idx, MAX_CYC);
        err_cnt++;
        finished = 1'b1;
      end else begin
        @(posedge clk_i);
        cyc++;
        // Single-cycle response pulse
        lsu_resp_valid_i <= c.lsu_req && (cyc == done_cyc);
      end
    end

    @(posedge clk_i);
    instr_valid_i     <= 1'b0;
    lsu_resp_valid_i  <= 1'b0;
    branch_decision_i <= 1'b0;
    @(negedge clk_i);
    check_idle();

    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("case %0d instr %h: ok after %0d cycles", idx, c.instr, cyc);
    end else begin
      fail_cnt++;
      $display("case %0d instr %h: mismatch, %0d errors", idx, c.instr, err_cnt - errs_before);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_rdata_i     = '0;
    pc_id_i           = '0;
    rf_rdata_a_i      = '0;
    rf_rdata_b_i      = '0;
    branch_decision_i = 1'b0;
    lsu_resp_valid_i  = 1'b0;

    repeat (RESET_CYC) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    // Stage comes out of reset idle
    check_idle();

    for (int i = 0; i < N_CASES; i++) begin
      run_case(i);
    end

    $display("%0d cases, %0d ok, %0d failed, %0d errors", N_CASES, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+verification
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_operand_mux.sv
logic/id_fsm.sv
logic/id_stage.sv
verification/id_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and look for the pass line

verilator --binary --timing --assert -f project.f --top-module id_stage_tb -Mdir obj_dir \
  && ./obj_dir/Vid_stage_tb | tee /dev/stderr | grep -q "Result: PASSED" \
  && echo "decode stage simulation passed" \
  || { echo "decode stage simulation failed"; exit 1; }
